//--- Makefile
# Verilator build and run of the RV64I core testbench.
# Override any variable on the command line, e.g. make run OBJ_DIR=build.

VERILATOR ?= verilator
TOP       ?= tb_rv_core
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

SOURCES := $(shell grep -v '^+' $(FLIST)) tb/tb_vectors.svh
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source, the table or the file list changes.
$(BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "Simulation PASSED"

clean:
	rm -rf $(OBJ_DIR)

//--- flist.f
+incdir+tb
source/rv_isa_pkg.sv
source/core_types_pkg.sv
source/inst_queue.sv
source/decoder.sv
source/alu.sv
source/reg_file.sv
source/execute_unit.sv
source/rv_core_top.sv
tb/tb_rv_core.sv

//--- source/alu.sv
// ==============================
// 64-bit integer ALU, purely combinational.
// Unused codes give zero.
// ==============================
`timescale 1ns/1ns
`default_nettype none

module alu (
  input  rv_isa_pkg::alu_op_t   op,
  input  core_types_pkg::xlen_t a,
  input  core_types_pkg::xlen_t b,
  output core_types_pkg::xlen_t result
);

  logic [5:0] shamt;
  assign shamt = b[5:0];  // RV64 shifts take six bits.

  always_comb begin
    unique case (op)
      rv_isa_pkg::alu_add:  result = a + b;
      rv_isa_pkg::alu_sub:  result = a - b;
      rv_isa_pkg::alu_slt:  result = {63'b0, $signed(a) < $signed(b)};
      rv_isa_pkg::alu_sltu: result = {63'b0, a < b};
      rv_isa_pkg::alu_and:  result = a & b;
      rv_isa_pkg::alu_or:   result = a | b;
      rv_isa_pkg::alu_xor:  result = a ^ b;
      rv_isa_pkg::alu_sll:  result = a << shamt;
      rv_isa_pkg::alu_srl:  result = a >> shamt;
      rv_isa_pkg::alu_sra:  result = $signed(a) >>> shamt;  // fills with the sign bit.
      default:              result = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- source/core_types_pkg.sv
// ==============================
// Datapath widths of the RV64 core.
// ==============================
`default_nettype none

package core_types_pkg;

  typedef logic [31:0] inst_t;    // one uncompressed instruction.
  typedef logic [63:0] xlen_t;    // register and data memory value.
  typedef logic [4:0]  reg_id_t;  // x0 to x31.
  typedef logic [63:0] pc_t;      // byte address of the instruction.

endpackage

`default_nettype wire

//--- source/decoder.sv
// ==============================
// Decodes the RV64I subset of the core.
// Anything else raises illegal and writes nothing.
// ==============================
`timescale 1ns/1ns
`default_nettype none

module decoder (
  input  core_types_pkg::inst_t   inst,
  output core_types_pkg::reg_id_t rd,
  output core_types_pkg::reg_id_t rs1,
  output core_types_pkg::reg_id_t rs2,
  output core_types_pkg::xlen_t   imm,
  output rv_isa_pkg::alu_op_t     alu_op,
  output logic                    need_imm,
  output logic                    is_lui,
  output logic                    is_auipc,
  output logic                    is_jal,
  output logic                    is_jalr,
  output logic                    is_load,
  output logic                    is_store,
  output logic                    is_ebreak,
  output logic                    reg_wen,
  output logic                    illegal
);

  // opcode and function field matches.
  logic opc_imm, opc_op, opc_load, opc_store, opc_system;
  logic f7_zero, f7_alt, sh_zero, sh_alt, f3_dword;
  logic [2:0] f3;

  assign f3         = inst[14:12];
  assign opc_imm    = (inst[6:0] == rv_isa_pkg::op_imm);
  assign opc_op     = (inst[6:0] == rv_isa_pkg::op_op);
  assign opc_load   = (inst[6:0] == rv_isa_pkg::op_load);
  assign opc_store  = (inst[6:0] == rv_isa_pkg::op_store);
  assign opc_system = (inst[6:0] == rv_isa_pkg::op_system);
  assign f7_zero    = (inst[31:25] == 7'b0000000);
  assign f7_alt     = (inst[31:25] == rv_isa_pkg::funct7_alt);
  assign sh_zero    = (inst[31:26] == 6'b000000);  // RV64 shamt is six bits wide.
  assign sh_alt     = (inst[31:26] == 6'b010000);
  assign f3_dword   = (f3 == rv_isa_pkg::funct3_dword);

  // per-instruction terms.
  logic addi, slti, sltiu, andi, ori, xori, slli, srli, srai;
  logic add, sub, slt, sltu, and_r, or_r, xor_r, sll, srl, sra;
  logic ld, sd, ebreak;

  assign addi  = opc_imm & (f3 == 3'b000);
  assign slti  = opc_imm & (f3 == 3'b010);
  assign sltiu = opc_imm & (f3 == 3'b011);
  assign xori  = opc_imm & (f3 == 3'b100);
  assign ori   = opc_imm & (f3 == 3'b110);
  assign andi  = opc_imm & (f3 == 3'b111);
  assign slli  = opc_imm & (f3 == 3'b001) & sh_zero;
  assign srli  = opc_imm & (f3 == 3'b101) & sh_zero;
  assign srai  = opc_imm & (f3 == 3'b101) & sh_alt;
  assign add   = opc_op & (f3 == 3'b000) & f7_zero;
  assign sub   = opc_op & (f3 == 3'b000) & f7_alt;
  assign sll   = opc_op & (f3 == 3'b001) & f7_zero;
  assign slt   = opc_op & (f3 == 3'b010) & f7_zero;
  assign sltu  = opc_op & (f3 == 3'b011) & f7_zero;
  assign xor_r = opc_op & (f3 == 3'b100) & f7_zero;
  assign srl   = opc_op & (f3 == 3'b101) & f7_zero;
  assign sra   = opc_op & (f3 == 3'b101) & f7_alt;
  assign or_r  = opc_op & (f3 == 3'b110) & f7_zero;
  assign and_r = opc_op & (f3 == 3'b111) & f7_zero;
  assign ld    = opc_load & f3_dword;
  assign sd    = opc_store & f3_dword;
  assign ebreak = opc_system & (f3 == 3'b000) & (inst[31:20] == rv_isa_pkg::funct12_ebreak);

  assign is_lui   = (inst[6:0] == rv_isa_pkg::op_lui);
  assign is_auipc = (inst[6:0] == rv_isa_pkg::op_auipc);
  assign is_jal   = (inst[6:0] == rv_isa_pkg::op_jal);
  assign is_jalr  = (inst[6:0] == rv_isa_pkg::op_jalr) & (f3 == 3'b000);
  assign is_load  = ld;
  assign is_store = sd;
  assign is_ebreak = ebreak;

  assign rd  = inst[11:7];
  assign rs1 = inst[19:15];
  assign rs2 = inst[24:20];

  // immediate by format. R-type and ebreak get zero.
  logic i_type, s_type, u_type, j_type;
  assign i_type = opc_imm | ld | is_jalr;
  assign s_type = sd;
  assign u_type = is_lui | is_auipc;
  assign j_type = is_jal;

  assign imm = ({64{i_type}} & {{52{inst[31]}}, inst[31:20]}) |
               ({64{s_type}} & {{52{inst[31]}}, inst[31:25], inst[11:7]}) |
               ({64{u_type}} & {{32{inst[31]}}, inst[31:12], 12'b0}) |
               ({64{j_type}} & {{44{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0});

  // the terms are exclusive. add is left for addresses, jumps and upper immediates.
  always_comb begin
    alu_op = rv_isa_pkg::alu_add;
    if (sub)                alu_op = rv_isa_pkg::alu_sub;
    if (slti | slt)         alu_op = rv_isa_pkg::alu_slt;
    if (sltiu | sltu)       alu_op = rv_isa_pkg::alu_sltu;
    if (andi | and_r)       alu_op = rv_isa_pkg::alu_and;
    if (ori | or_r)         alu_op = rv_isa_pkg::alu_or;
    if (xori | xor_r)       alu_op = rv_isa_pkg::alu_xor;
    if (slli | sll)         alu_op = rv_isa_pkg::alu_sll;
    if (srli | srl)         alu_op = rv_isa_pkg::alu_srl;
    if (srai | sra)         alu_op = rv_isa_pkg::alu_sra;
  end

  assign need_imm = i_type | s_type | u_type | j_type;  // b takes imm instead of rs2.
  assign reg_wen  = addi | slti | sltiu | andi | ori | xori | slli | srli | srai |
                    add | sub | slt | sltu | and_r | or_r | xor_r | sll | srl | sra |
                    is_lui | is_auipc | is_jal | is_jalr | ld;
  assign illegal  = ~(reg_wen | sd | ebreak);  // every implemented non-writer is listed.

endmodule

`default_nettype wire

//--- source/execute_unit.sv
// ==============================
// Single-cycle execute with pc and data memory.
// Jumps move the pc only. Nothing is fetched.
// Data words are selected by address bits 2 up.
// ==============================
`timescale 1ns/1ns
`default_nettype none

module execute_unit #(
  parameter int mem_words         = 16,
  parameter int retire_credit_max = 8
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    head_valid,
  input  logic                    need_imm,
  input  logic                    is_lui,
  input  logic                    is_auipc,
  input  logic                    is_jal,
  input  logic                    is_jalr,
  input  logic                    is_load,
  input  logic                    is_store,
  input  logic                    is_ebreak,
  input  logic                    reg_wen,
  input  logic                    illegal,
  input  core_types_pkg::reg_id_t rd,
  input  core_types_pkg::xlen_t   imm,
  input  core_types_pkg::xlen_t   rdata1,
  input  core_types_pkg::xlen_t   rdata2,
  output core_types_pkg::xlen_t   alu_a,
  output core_types_pkg::xlen_t   alu_b,
  input  core_types_pkg::xlen_t   alu_result,
  output logic                    issue,
  output logic                    wen,
  output core_types_pkg::reg_id_t waddr,
  output core_types_pkg::xlen_t   wdata,
  input  logic                    retire_credit,
  output logic                    retire_valid,
  output core_types_pkg::pc_t     retire_pc,
  output core_types_pkg::reg_id_t retire_rd,
  output core_types_pkg::xlen_t   retire_data,
  output logic                    retire_wen,
  output logic                    retire_illegal,
  output logic                    retire_ebreak,
  output logic                    halted
);

  localparam int credit_w = $clog2(retire_credit_max + 1);
  localparam int idx_w    = (mem_words > 1) ? $clog2(mem_words) : 1;

  typedef enum logic {st_run, st_halt} state_t;

  state_t                state;
  logic [credit_w-1:0]   credit_cnt;
  core_types_pkg::pc_t   pc;
  core_types_pkg::pc_t   pc_plus4;
  core_types_pkg::pc_t   next_pc;
  core_types_pkg::xlen_t dmem [mem_words];
  core_types_pkg::xlen_t word_sel;
  logic [idx_w-1:0]      mem_idx;

  // issue needs a queued instruction, a retire credit and a running core.
  assign issue = (state == st_run) && head_valid && (credit_cnt != '0);
  assign halted = (state == st_halt);

  // operand select. lui adds its immediate to zero.
  assign alu_a = (is_auipc || is_jal) ? pc : (is_lui ? '0 : rdata1);
  assign alu_b = need_imm ? imm : rdata2;

  assign pc_plus4 = pc + 64'd4;  // also the link value of jal and jalr.
  assign next_pc  = is_jal  ? alu_result :
                    is_jalr ? {alu_result[63:1], 1'b0} : pc_plus4;

  // address from the ALU sum. Wraps modulo mem_words.
  assign word_sel = (alu_result >> 2) % core_types_pkg::xlen_t'(mem_words);
  assign mem_idx  = word_sel[idx_w-1:0];

  assign wen   = issue && reg_wen;
  assign waddr = rd;
  assign wdata = is_load ? dmem[mem_idx] : ((is_jal || is_jalr) ? pc_plus4 : alu_result);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state        <= st_run;
      credit_cnt   <= '0;
      pc           <= '0;
      retire_valid <= 1'b0;
    end else begin
      retire_valid <= issue;
      if (issue) pc <= next_pc;
      if (issue && is_ebreak) state <= st_halt;  // halt stays until reset.
      // a grant and a spend in one cycle cancel out.
      if (retire_credit && !issue) begin
        if (credit_cnt != credit_w'(retire_credit_max)) credit_cnt <= credit_cnt + 1'b1;
      end else if (!retire_credit && issue) begin
        credit_cnt <= credit_cnt - 1'b1;
      end
    end
  end

  // data memory comes up zeroed.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < mem_words; i++) dmem[i] <= '0;
    end else if (issue && is_store) begin
      dmem[mem_idx] <= rdata2;
    end
  end

  // retire record. retire_valid qualifies it.
  always_ff @(posedge clk) begin
    if (issue) begin
      retire_pc      <= pc;
      retire_rd      <= rd;
      retire_data    <= is_store ? rdata2 : (reg_wen ? wdata : '0);  // zero when illegal.
      retire_wen     <= reg_wen;
      retire_illegal <= illegal;
      retire_ebreak  <= is_ebreak;
    end
  end

endmodule

`default_nettype wire

//--- source/inst_queue.sv
// ==============================
// The sender never pushes into a full queue.
// Its credits make sure of that.
// ==============================
`timescale 1ns/1ns
`default_nettype none

module inst_queue #(
  parameter int queue_depth = 4
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  push,
  input  core_types_pkg::inst_t push_inst,
  input  logic                  pop,
  output core_types_pkg::inst_t head_inst,
  output logic                  head_valid,
  output logic                  credit
);

  localparam int ptr_w = (queue_depth > 1) ? $clog2(queue_depth) : 1;
  localparam int cnt_w = $clog2(queue_depth + 1);

  core_types_pkg::inst_t slots [queue_depth];
  logic [ptr_w-1:0] rd_ptr;
  logic [ptr_w-1:0] wr_ptr;
  logic [cnt_w-1:0] count;

  // pointers wrap at queue_depth, which need not be a power of two.
  function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] p);
    return (p == ptr_w'(queue_depth - 1)) ? '0 : p + 1'b1;
  endfunction

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
      credit <= 1'b0;
    end else begin
      credit <= pop;  // the slot is already free when the sender sees this.
      if (push) wr_ptr <= ptr_inc(wr_ptr);
      if (pop) rd_ptr <= ptr_inc(rd_ptr);
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // both or neither leave the fill level as it is.
      endcase
    end
  end

  // the entries themselves hold payload only.
  always_ff @(posedge clk) begin
    if (push) slots[wr_ptr] <= push_inst;
  end

  assign head_inst  = slots[rd_ptr];
  assign head_valid = (count != '0);

endmodule

`default_nettype wire

//--- source/reg_file.sv
// ==============================
// Two read ports and one write port.
// x0 always reads zero.
// ==============================
`timescale 1ns/1ns
`default_nettype none

module reg_file (
  input  logic                    clk,
  input  logic                    rst_n,
  input  core_types_pkg::reg_id_t raddr1,
  input  core_types_pkg::reg_id_t raddr2,
  output core_types_pkg::xlen_t   rdata1,
  output core_types_pkg::xlen_t   rdata2,
  input  logic                    wen,
  input  core_types_pkg::reg_id_t waddr,
  input  core_types_pkg::xlen_t   wdata
);

  core_types_pkg::xlen_t regs [32];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) regs[i] <= '0;
    end else if (wen && (waddr != '0)) begin
      regs[waddr] <= wdata;  // a write to x0 is dropped here.
    end
  end

  assign rdata1 = regs[raddr1];  // reads see the value before this cycle's write.
  assign rdata2 = regs[raddr2];

endmodule

`default_nettype wire

//--- source/rv_core_top.sv
// ==============================
// RV64I execute core with credit flow control.
// The sender starts with queue_depth credits.
// ==============================
`timescale 1ns/1ns
`default_nettype none

module rv_core_top #(
  parameter int queue_depth       = 4,
  parameter int mem_words         = 16,
  parameter int retire_credit_max = 8
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    inst_valid,
  input  core_types_pkg::inst_t   inst,
  output logic                    inst_credit,
  input  logic                    retire_credit,
  output logic                    retire_valid,
  output core_types_pkg::pc_t     retire_pc,
  output core_types_pkg::reg_id_t retire_rd,
  output core_types_pkg::xlen_t   retire_data,
  output logic                    retire_wen,
  output logic                    retire_illegal,
  output logic                    retire_ebreak,
  output logic                    halted
);

  core_types_pkg::inst_t   head_inst;
  logic                    head_valid, issue;
  core_types_pkg::reg_id_t rd, rs1, rs2, waddr;
  core_types_pkg::xlen_t   imm, rdata1, rdata2, alu_a, alu_b, alu_result, wdata;
  rv_isa_pkg::alu_op_t     alu_op;
  logic need_imm, is_lui, is_auipc, is_jal, is_jalr, is_load, is_store, is_ebreak;
  logic reg_wen, illegal, wen;

  inst_queue #(.queue_depth(queue_depth)) inst_queue_i (
    .clk(clk), .rst_n(rst_n), .push(inst_valid), .push_inst(inst), .pop(issue),
    .head_inst(head_inst), .head_valid(head_valid), .credit(inst_credit)
  );

  decoder decoder_i (
    .inst(head_inst), .rd(rd), .rs1(rs1), .rs2(rs2), .imm(imm), .alu_op(alu_op),
    .need_imm(need_imm), .is_lui(is_lui), .is_auipc(is_auipc), .is_jal(is_jal),
    .is_jalr(is_jalr), .is_load(is_load), .is_store(is_store), .is_ebreak(is_ebreak),
    .reg_wen(reg_wen), .illegal(illegal)
  );

  reg_file reg_file_i (
    .clk(clk), .rst_n(rst_n), .raddr1(rs1), .raddr2(rs2), .rdata1(rdata1),
    .rdata2(rdata2), .wen(wen), .waddr(waddr), .wdata(wdata)
  );

  alu alu_i (.op(alu_op), .a(alu_a), .b(alu_b), .result(alu_result));

  execute_unit #(
    .mem_words(mem_words),
    .retire_credit_max(retire_credit_max)
  ) execute_unit_i (
    .clk(clk), .rst_n(rst_n), .head_valid(head_valid), .need_imm(need_imm),
    .is_lui(is_lui), .is_auipc(is_auipc), .is_jal(is_jal), .is_jalr(is_jalr),
    .is_load(is_load), .is_store(is_store), .is_ebreak(is_ebreak), .reg_wen(reg_wen),
    .illegal(illegal), .rd(rd), .imm(imm), .rdata1(rdata1), .rdata2(rdata2),
    .alu_a(alu_a), .alu_b(alu_b), .alu_result(alu_result), .issue(issue),
    .wen(wen), .waddr(waddr), .wdata(wdata), .retire_credit(retire_credit),
    .retire_valid(retire_valid), .retire_pc(retire_pc), .retire_rd(retire_rd),
    .retire_data(retire_data), .retire_wen(retire_wen),
    .retire_illegal(retire_illegal), .retire_ebreak(retire_ebreak), .halted(halted)
  );

endmodule

`default_nettype wire

//--- source/rv_isa_pkg.sv
// ==============================
// RV64I encodings for the subset the core runs.
// ALU codes are plain numbers, not one-hot.
// ==============================
`default_nettype none

package rv_isa_pkg;

  typedef logic [6:0] opcode_t;  // major opcode, inst[6:0].
  typedef logic [3:0] alu_op_t;  // room for sixteen codes, ten are used.

  // major opcodes of the implemented instruction groups.
  localparam opcode_t op_imm    = 7'b0010011;
  localparam opcode_t op_op     = 7'b0110011;
  localparam opcode_t op_lui    = 7'b0110111;
  localparam opcode_t op_auipc  = 7'b0010111;
  localparam opcode_t op_jal    = 7'b1101111;
  localparam opcode_t op_jalr   = 7'b1100111;
  localparam opcode_t op_load   = 7'b0000011;
  localparam opcode_t op_store  = 7'b0100011;
  localparam opcode_t op_system = 7'b1110011;

  localparam logic [2:0]  funct3_dword   = 3'b011;         // ld and sd width.
  localparam logic [6:0]  funct7_alt     = 7'b0100000;     // sub and sra.
  localparam logic [11:0] funct12_ebreak = 12'b000000000001;

  // ALU operation codes.
  localparam alu_op_t alu_add  = 4'd0;
  localparam alu_op_t alu_sub  = 4'd1;
  localparam alu_op_t alu_slt  = 4'd2;
  localparam alu_op_t alu_sltu = 4'd3;
  localparam alu_op_t alu_and  = 4'd4;
  localparam alu_op_t alu_or   = 4'd5;
  localparam alu_op_t alu_xor  = 4'd6;
  localparam alu_op_t alu_sll  = 4'd7;
  localparam alu_op_t alu_srl  = 4'd8;
  localparam alu_op_t alu_sra  = 4'd9;

endpackage

`default_nettype wire

//--- tb/tb_vectors.svh
// ==============================
// Rows must retire in this order. pc values assume the sender
// streams the jump target next. Columns are name, instruction,
// pc, rd, data and {wen, illegal, ebreak}.
// ==============================

task automatic fill_table();
  // x1 = 5 and x2 = -3 feed most of the rows below.
  add_row("addi x1", imm_op(1, 0, 3'b000, 5), 'h00, 1, 64'h5, 3'b100);
  add_row("addi x2", imm_op(2, 0, 3'b000, -3), 'h04, 2, 64'hffff_ffff_ffff_fffd, 3'b100);
  add_row("add x3", reg_op(3, 1, 2, 3'b000, 0), 'h08, 3, 64'h2, 3'b100);
  add_row("sub x4", reg_op(4, 1, 2, 3'b000, 1), 'h0c, 4, 64'h8, 3'b100);
  add_row("andi x5", imm_op(5, 2, 3'b111, 'hf0), 'h10, 5, 64'hf0, 3'b100);
  add_row("or x6", reg_op(6, 1, 5, 3'b110, 0), 'h14, 6, 64'hf5, 3'b100);
  add_row("xor x7", reg_op(7, 6, 2, 3'b100, 0), 'h18, 7, 64'hffff_ffff_ffff_ff08, 3'b100);
  add_row("sll x8", reg_op(8, 1, 4, 3'b001, 0), 'h1c, 8, 64'h500, 3'b100);
  add_row("addi x9", imm_op(9, 0, 3'b000, 68), 'h20, 9, 64'h44, 3'b100);
  add_row("sll x10", reg_op(10, 1, 9, 3'b001, 0), 'h24, 10, 64'h50, 3'b100);  // 68 shifts by 4.
  add_row("srl x11", reg_op(11, 2, 1, 3'b101, 0), 'h28, 11, 64'h07ff_ffff_ffff_ffff, 3'b100);
  add_row("sra x12", reg_op(12, 2, 1, 3'b101, 1), 'h2c, 12, 64'hffff_ffff_ffff_ffff, 3'b100);
  add_row("slli x13", imm_op(13, 1, 3'b001, 40), 'h30, 13, 64'h0000_0500_0000_0000, 3'b100);
  add_row("srai x14", imm_op(14, 7, 3'b101, 'h404), 'h34, 14, 64'hffff_ffff_ffff_fff0, 3'b100);
  add_row("slt x15", reg_op(15, 2, 1, 3'b010, 0), 'h38, 15, 64'h1, 3'b100);
  add_row("sltu x16", reg_op(16, 2, 1, 3'b011, 0), 'h3c, 16, 64'h0, 3'b100);
  add_row("addi x0", imm_op(0, 1, 3'b000, 7), 'h40, 0, 64'hc, 3'b100);
  add_row("add x17", reg_op(17, 0, 1, 3'b000, 0), 'h44, 17, 64'h5, 3'b100);  // x0 reads zero.
  // 0x18 and 0x98 are mem_words doublewords apart and hit the same word.
  add_row("addi x18", imm_op(18, 0, 3'b000, 'h18), 'h48, 18, 64'h18, 3'b100);
  add_row("sd x7", store_dword(7, 18, 0), 'h4c, 0, 64'hffff_ffff_ffff_ff08, 3'b000);
  add_row("ld x19", load_dword(19, 18, 0), 'h50, 19, 64'hffff_ffff_ffff_ff08, 3'b100);
  add_row("ld x20", load_dword(20, 18, 'h80), 'h54, 20, 64'hffff_ffff_ffff_ff08, 3'b100);
  add_row("lui x21", upper_imm(21, 'h12345), 'h58, 21, 64'h1234_5000, 3'b100);
  add_row("lui x22", upper_imm(22, 'h80000), 'h5c, 22, 64'hffff_ffff_8000_0000, 3'b100);
  add_row("auipc x23", pc_upper(23, 'h1), 'h60, 23, 64'h1060, 3'b100);
  add_row("jal x24", jump_link(24, 'h100), 'h64, 24, 64'h68, 3'b100);
  add_row("addi x25", imm_op(25, 0, 3'b000, 'h200), 'h164, 25, 64'h200, 3'b100);
  add_row("jalr x26", jump_reg(26, 25, 'h21), 'h168, 26, 64'h16c, 3'b100);  // bit 0 drops.
  add_row("custom x1", raw_i(7'b0001011, 1, 0, 0), 'h220, 1, 64'h0, 3'b010);
  add_row("addi x27", imm_op(27, 1, 3'b000, 0), 'h224, 27, 64'h5, 3'b100);
  add_row("ebreak", raw_i(rv_isa_pkg::op_system, 0, 0, 1), 'h228, 0, 64'h0, 3'b001);
  extra_word = imm_op(28, 0, 3'b000, 1);  // pushed after the halt and must never retire.
endtask

//--- tb/tb_rv_core.sv
// ==============================
// Runs rv_core_top with default parameters.
// Retire credits stall first, then follow a seeded random pattern.
// ==============================
`timescale 1ns/1ns
`default_nettype none

module tb_rv_core;

  localparam int queue_depth    = 4;  // the DUT default, also the sender's starting credits.
  localparam int reset_cycles   = 8;
  localparam int num_tests      = 31;
  localparam int stall_cycles   = 20;
  localparam int idle_cycles    = 20;
  localparam int timeout_cycles = num_tests * 40 + reset_cycles;

  logic                    clk;
  logic                    rst_n;
  logic                    inst_valid;
  core_types_pkg::inst_t   inst;
  logic                    inst_credit;
  logic                    retire_credit;
  logic                    retire_valid;
  core_types_pkg::pc_t     retire_pc;
  core_types_pkg::reg_id_t retire_rd;
  core_types_pkg::xlen_t   retire_data;
  logic                    retire_wen;
  logic                    retire_illegal;
  logic                    retire_ebreak;
  logic                    halted;

  string                   test_name [num_tests];
  core_types_pkg::inst_t   test_inst [num_tests];
  core_types_pkg::pc_t     exp_pc    [num_tests];
  core_types_pkg::reg_id_t exp_rd    [num_tests];
  core_types_pkg::xlen_t   exp_data  [num_tests];
  logic [2:0]              exp_flags [num_tests];  // {wen, illegal, ebreak}.
  core_types_pkg::inst_t   extra_word;

  int row_count     = 0;
  int retire_count  = 0;
  int tests_passed  = 0;
  int tests_failed  = 0;
  int other_errors  = 0;
  int credit_pulses = 0;
  int grants        = 0;
  int send_credits  = queue_depth;
  int cycle_count   = 0;
  bit table_done    = 1'b0;
  bit extra_pushed  = 1'b0;

  rv_core_top rv_core_top_i (
    .clk(clk), .rst_n(rst_n), .inst_valid(inst_valid), .inst(inst),
    .inst_credit(inst_credit), .retire_credit(retire_credit),
    .retire_valid(retire_valid), .retire_pc(retire_pc), .retire_rd(retire_rd),
    .retire_data(retire_data), .retire_wen(retire_wen),
    .retire_illegal(retire_illegal), .retire_ebreak(retire_ebreak), .halted(halted)
  );

  // instruction encoders for the formats the table uses.
  function automatic core_types_pkg::inst_t imm_op(input int rd, input int rs1,
                                                   input logic [2:0] f3, input int imm);
    return {12'(imm), 5'(rs1), f3, 5'(rd), rv_isa_pkg::op_imm};
  endfunction

  function automatic core_types_pkg::inst_t reg_op(input int rd, input int rs1, input int rs2,
                                                   input logic [2:0] f3, input bit alt);
    logic [6:0] f7;
    f7 = alt ? rv_isa_pkg::funct7_alt : 7'b0000000;  // alt picks sub and sra.
    return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), rv_isa_pkg::op_op};
  endfunction

  function automatic core_types_pkg::inst_t raw_i(input logic [6:0] op, input int rd,
                                                  input int rs1, input int imm);
    return {12'(imm), 5'(rs1), 3'b000, 5'(rd), op};
  endfunction

  function automatic core_types_pkg::inst_t load_dword(input int rd, input int rs1,
                                                       input int offset);
    return {12'(offset), 5'(rs1), rv_isa_pkg::funct3_dword, 5'(rd), rv_isa_pkg::op_load};
  endfunction

  function automatic core_types_pkg::inst_t store_dword(input int rs2, input int rs1,
                                                        input int offset);
    logic [11:0] o;
    o = 12'(offset);  // S format splits the offset around rs1 and rs2.
    return {o[11:5], 5'(rs2), 5'(rs1), rv_isa_pkg::funct3_dword, o[4:0], rv_isa_pkg::op_store};
  endfunction

  function automatic core_types_pkg::inst_t upper_imm(input int rd, input int imm20);
    return {20'(imm20), 5'(rd), rv_isa_pkg::op_lui};
  endfunction

  function automatic core_types_pkg::inst_t pc_upper(input int rd, input int imm20);
    return {20'(imm20), 5'(rd), rv_isa_pkg::op_auipc};
  endfunction

  function automatic core_types_pkg::inst_t jump_link(input int rd, input int offset);
    logic [20:0] o;
    o = 21'(offset);
    return {o[20], o[10:1], o[11], o[19:12], 5'(rd), rv_isa_pkg::op_jal};
  endfunction

  function automatic core_types_pkg::inst_t jump_reg(input int rd, input int rs1,
                                                     input int offset);
    return {12'(offset), 5'(rs1), 3'b000, 5'(rd), rv_isa_pkg::op_jalr};
  endfunction

  task automatic add_row(input string name, input core_types_pkg::inst_t word,
                         input core_types_pkg::pc_t pc, input int rd,
                         input core_types_pkg::xlen_t data, input logic [2:0] flags);
    test_name[row_count] = name;
    test_inst[row_count] = word;
    exp_pc[row_count]    = pc;
    exp_rd[row_count]    = 5'(rd);
    exp_data[row_count]  = data;
    exp_flags[row_count] = flags;
    row_count++;
  endtask

  `include "tb_vectors.svh"

  // compares one retire record with the next row in order.
  task automatic check_retire();
    int errs;
    int r;
    errs = 0;
    r = retire_count;
    assert (retire_count < grants) else begin
      $display("retire at pc %h came without an unspent retire credit", retire_pc);
      other_errors++;
    end
    assert (r < num_tests) else begin
      $display("an instruction retired after the table ended, pc %h", retire_pc);
      other_errors++;
    end
    if (r < num_tests) begin
      assert (retire_pc == exp_pc[r]) else begin
        $display("error %s: pc expected %h actual %h", test_name[r], exp_pc[r], retire_pc);
        errs++;
      end
      assert (retire_rd == exp_rd[r]) else begin
        $display("error %s: rd expected %0d actual %0d", test_name[r], exp_rd[r], retire_rd);
        errs++;
      end
      assert (retire_data == exp_data[r]) else begin
        $display("error %s: data expected %h actual %h", test_name[r], exp_data[r],
                 retire_data);
        errs++;
      end
      assert ({retire_wen, retire_illegal, retire_ebreak} == exp_flags[r]) else begin
        $display("error %s: wen/illegal/ebreak expected %b actual %b", test_name[r],
                 exp_flags[r], {retire_wen, retire_illegal, retire_ebreak});
        errs++;
      end
      // halted rises at the same edge as the ebreak retire, and not before.
      assert (halted == (r == num_tests - 1)) else begin
        $display("error %s: halted expected %b actual %b", test_name[r],
                 (r == num_tests - 1), halted);
        errs++;
      end
      if (errs == 0) begin
        tests_passed++;
        $display("pass %s", test_name[r]);
      end else begin
        tests_failed++;
        $display("fail %s", test_name[r]);
      end
    end
    retire_count++;
    if (retire_count == num_tests) table_done = 1'b1;
  endtask

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin : main
    rst_n = 1'b0;
    inst_valid = 1'b0;
    inst = '0;
    retire_credit = 1'b0;
    fill_table();
    repeat (reset_cycles) @(posedge clk);
    rst_n <= 1'b1;
    wait (table_done && extra_pushed);
    repeat (idle_cycles) @(posedge clk);  // the extra instruction must stay queued.
    assert (credit_pulses == retire_count) else begin
      $display("inst_credit pulsed %0d times for %0d retires", credit_pulses, retire_count);
      other_errors++;
    end
    assert (halted) else begin
      $display("halted dropped after the ebreak retired");
      other_errors++;
    end
    $display("tests %0d, passed %0d, failed %0d, other errors %0d", num_tests, tests_passed,
             tests_failed, other_errors);
    if (tests_failed == 0 && other_errors == 0 && tests_passed == num_tests) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  // the sender pushes only while it holds a credit.
  initial begin : sender
    int idx;
    idx = 0;
    wait (rst_n === 1'b1);
    while (!extra_pushed) begin
      @(posedge clk);
      if (inst_credit) send_credits++;  // pulse registered at the previous edge.
      assert (send_credits <= queue_depth) else begin
        $display("the core returned more credits than the queue has slots");
        other_errors++;
      end
      if (send_credits > 0 && (idx < num_tests || halted)) begin
        inst_valid <= 1'b1;
        inst <= (idx < num_tests) ? test_inst[idx] : extra_word;
        if (idx == num_tests) extra_pushed = 1'b1;
        idx++;
        send_credits--;
      end else begin
        inst_valid <= 1'b0;
      end
    end
    @(posedge clk);
    inst_valid <= 1'b0;
  end

  // no grants at first, so the queue fills and the sender runs dry.
  initial begin : credit_source
    int unsigned seed_draw;
    seed_draw = $urandom(32'hc817);  // one seed for the whole run, in the process that draws.
    wait (rst_n === 1'b1);
    repeat (stall_cycles) @(posedge clk);
    @(negedge clk);
    assert (send_credits == 0 && retire_count == 0) else begin
      $display("back-pressure did not stop the sender, %0d credits left", send_credits);
      other_errors++;
    end
    forever begin
      @(posedge clk);
      retire_credit <= (($urandom % 2) == 1);
    end
  end

  // outputs are sampled mid-cycle where they are settled.
  always @(negedge clk) begin
    if (rst_n) begin
      if (inst_credit) credit_pulses++;
      if (retire_valid) check_retire();
      if (retire_credit) grants++;  // the DUT only sees this grant at the next edge.
    end
  end

  initial begin : watchdog
    while (cycle_count < timeout_cycles) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout after %0d cycles with %0d of %0d rows retired", cycle_count,
             retire_count, num_tests);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

`default_nettype wire
